// ==== hilo_div.f ====
hilo_div_pkg.sv
div_step_if.sv
div_ctrl_fsm.sv
div_step_counter.sv
div_datapath.sv
hilo_regs.sv
hilo_div.sv
div_props.sv
div_checker.sv
tb_hilo_div.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator; pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1
log_file="sim.log"

verilator --binary --timing --assert --top-module tb_hilo_div \
    --Mdir obj_dir -o sim_hilo_div -f hilo_div.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_hilo_div > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log_file"; then
    exit 0
fi
exit 1

// ==== tb_hilo_div.sv ====
// testbench top for the HI/LO divide unit
// stimulus changes on the falling edge, drawn from a Galois LFSR with a fixed seed
// all result checking lives in div_checker
`default_nettype none

module tb_hilo_div;

    localparam int NUM_OPS = 240;
    localparam int WAIT_MAX = 40;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 2000;
    localparam logic [31:0] LFSR_SEED = 32'h77ba1df5;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk, rst, start_i, signed_i, cancel_i, hi_we_i, lo_we_i;
    logic busy_o, done_o;
    hilo_div_pkg::word_t dividend_i, divisor_i, wdata_i, hi_o, lo_o;
    logic [31:0] lfsr_state;
    int mismatches, checks, stalls;

    hilo_div dut (.*);

    div_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .signed_i   (signed_i),
        .cancel_i   (cancel_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .hi_we_i    (hi_we_i),
        .lo_we_i    (lo_we_i),
        .wdata_i    (wdata_i),
        .busy_i     (busy_o),
        .done_i     (done_o),
        .hi_i       (hi_o),
        .lo_i       (lo_o),
        .errors_o   (mismatches),
        .checks_o   (checks)
    );

    always #5 clk = ~clk;

    // one LFSR step per bit taken
    function automatic logic take_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    function automatic hilo_div_pkg::word_t take_bits(input int n);
        hilo_div_pkg::word_t val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = {val[30:0], take_bit()};
        end
        return val;
    endfunction

    // corner values often enough to reach the sign and zero cases
    function automatic hilo_div_pkg::word_t pick_operand();
        case (take_bits(3))
            32'd0: return '0;
            32'd1: return 32'd1;
            32'd2: return 32'h8000_0000;
            32'd3: return '1;
            32'd4: return take_bits(8);
            default: return take_bits(32);
        endcase
    endfunction

    // mode 4 cancels, 5 restarts while busy, 6 writes mid-run, 7 writes with done_o
    task automatic run_division(input logic sgn, input hilo_div_pkg::word_t a,
                                input hilo_div_pkg::word_t b, input int mode);
        int mid;
        int n;
        mid = int'(take_bits(4));
        n = 0;
        signed_i = sgn;
        dividend_i = a;
        divisor_i = b;
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        // operands were captured at the start edge
        dividend_i = take_bits(32);
        divisor_i = take_bits(32);
        if (mode == 7) begin
            while (!done_o && n < WAIT_MAX) begin
                @(negedge clk);
                n++;
            end
        end else begin
            repeat (mid) @(negedge clk);
        end
        cancel_i = (mode == 4);
        start_i = (mode == 5);
        hi_we_i = (mode >= 6);
        lo_we_i = (mode >= 6);
        wdata_i = take_bits(32);
        @(negedge clk);
        cancel_i = 1'b0;
        start_i = 1'b0;
        hi_we_i = 1'b0;
        lo_we_i = 1'b0;
        n = 0;
        while (busy_o && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            stalls++;
            $display("busy_o did not fall within %0d cycles at time %0t", WAIT_MAX, $time);
        end
        // idle gap with optional direct writes
        hi_we_i = take_bit();
        lo_we_i = take_bit();
        wdata_i = take_bits(32);
        @(negedge clk);
        hi_we_i = 1'b0;
        lo_we_i = 1'b0;
        repeat (int'(take_bits(2))) @(negedge clk);
    endtask

    initial begin
        logic sgn;
        hilo_div_pkg::word_t a;
        hilo_div_pkg::word_t b;
        int mode;
        int total;
        clk = 1'b0;
        rst = 1'b1;
        start_i = 1'b0;
        signed_i = 1'b0;
        cancel_i = 1'b0;
        hi_we_i = 1'b0;
        lo_we_i = 1'b0;
        dividend_i = '0;
        divisor_i = '0;
        wdata_i = '0;
        lfsr_state = LFSR_SEED;
        stalls = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        run_division(1'b1, 32'h8000_0000, 32'hffff_ffff, 0);
        run_division(1'b1, 32'hffff_fff9, 32'd2, 0);
        run_division(1'b0, 32'hdead_beef, 32'd0, 7);
        run_division(1'b0, 32'hffff_ffff, 32'd10, 4);
        for (int i = 0; i < NUM_OPS; i++) begin
            sgn = take_bit();
            a = pick_operand();
            b = pick_operand();
            mode = int'(take_bits(3));
            run_division(sgn, a, b, mode);
        end
        repeat (2) @(negedge clk);
        total = mismatches + stalls;
        $display("checks %0d, mismatches %0d, stalls %0d, errors %0d",
                 checks, mismatches, stalls, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== div_checker.sv ====
// scoreboard for the HI/LO divide unit, sampled on every rising edge
// outputs are compared first, then the model takes the edge's inputs
`default_nettype none

module div_checker (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start_i,
    input  wire logic                signed_i,
    input  wire logic                cancel_i,
    input  wire hilo_div_pkg::word_t dividend_i,
    input  wire hilo_div_pkg::word_t divisor_i,
    input  wire logic                hi_we_i,
    input  wire logic                lo_we_i,
    input  wire hilo_div_pkg::word_t wdata_i,
    input  wire logic                busy_i,
    input  wire logic                done_i,
    input  wire hilo_div_pkg::word_t hi_i,
    input  wire hilo_div_pkg::word_t lo_i,
    output int                       errors_o,
    output int                       checks_o
);

    hilo_div_pkg::div_state_e m_state;
    hilo_div_pkg::word_t m_hi, m_lo, res_hi, res_lo;
    int m_steps;
    logic exp_done;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    // quotient truncates toward zero, remainder keeps the dividend sign
    task automatic model_divide(input logic sgn, input hilo_div_pkg::word_t a,
                                input hilo_div_pkg::word_t b,
                                output hilo_div_pkg::word_t q,
                                output hilo_div_pkg::word_t r);
        logic a_neg;
        logic b_neg;
        hilo_div_pkg::word_t a_mag;
        hilo_div_pkg::word_t b_mag;
        a_neg = sgn && a[31];
        b_neg = sgn && b[31];
        a_mag = a_neg ? -a : a;
        b_mag = b_neg ? -b : b;
        if (b == '0) begin
            q = '0;
            r = '0;
        end else begin
            q = (a_neg != b_neg) ? -(a_mag / b_mag) : a_mag / b_mag;
            r = a_neg ? -(a_mag % b_mag) : a_mag % b_mag;
        end
    endtask

    task automatic check_value(input string name, input hilo_div_pkg::word_t got,
                               input hilo_div_pkg::word_t exp);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("[ERROR] %s: got %08h expected %08h at time %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_state = hilo_div_pkg::IDLE;
            m_steps = 0;
            m_hi = '0;
            m_lo = '0;
            res_hi = '0;
            res_lo = '0;
        end else begin
            exp_done = (m_state == hilo_div_pkg::DONE) && !cancel_i;
            check_value("busy_o", {31'b0, busy_i}, {31'b0, m_state != hilo_div_pkg::IDLE});
            check_value("hi_o", hi_i, m_hi);
            check_value("lo_o", lo_i, m_lo);
            checks_o++;
            if (done_i !== exp_done) begin
                errors_o++;
                if (exp_done) begin
                    $display("done_o missing where the division should finish, time %0t",
                             $time);
                end else begin
                    $display("unexpected done_o at time %0t", $time);
                end
            end
            // the divider result beats a direct write on the same edge
            if (exp_done) begin
                m_hi = res_hi;
                m_lo = res_lo;
            end else begin
                if (hi_we_i) begin
                    m_hi = wdata_i;
                end
                if (lo_we_i) begin
                    m_lo = wdata_i;
                end
            end
            case (m_state)
                hilo_div_pkg::IDLE: begin
                    if (start_i) begin
                        model_divide(signed_i, dividend_i, divisor_i, res_lo, res_hi);
                        m_steps = 0;
                        if (divisor_i == '0) begin
                            m_state = hilo_div_pkg::DONE;
                        end else begin
                            m_state = hilo_div_pkg::RUN;
                        end
                    end
                end
                hilo_div_pkg::RUN: begin
                    m_steps++;
                    if (cancel_i) begin
                        m_state = hilo_div_pkg::IDLE;
                    end else if (m_steps == hilo_div_pkg::DIV_STEPS) begin
                        m_state = hilo_div_pkg::DONE;
                    end
                end
                default: begin
                    m_state = hilo_div_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== div_props.sv ====
// controller properties, bound into every div_ctrl_fsm instance
// not checked while rst is high
`default_nettype none

module div_props (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     busy_i,
    input wire logic                     done_i,
    input wire logic                     load_i,
    input wire hilo_div_pkg::div_state_e state_i
);

    done_single: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
        else $error("done_o high on two consecutive cycles");

    done_idle: assert property (@(posedge clk) disable iff (rst) done_i |=> !busy_i)
        else $error("busy_o still high in the cycle after done_o");

    load_leaves_idle: assert property (@(posedge clk) disable iff (rst)
        load_i |=> state_i != hilo_div_pkg::IDLE)
        else $error("controller still IDLE after an operand load");

endmodule

bind div_ctrl_fsm div_props u_props (
    .clk     (clk),
    .rst     (rst),
    .busy_i  (busy_o),
    .done_i  (done_o),
    .load_i  (bus.load),
    .state_i (state_q)
);

`default_nettype wire

// ==== hilo_div.sv ====
// divide unit with HI/LO pair and a plain strobe interface
// done_o pulses 32 cycles after an accepted start, 0 for a zero divisor
// start_i is ignored while busy_o is high; no result hold or handshake
`default_nettype none

module hilo_div (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start_i,
    input  wire logic                signed_i,
    input  wire logic                cancel_i,
    input  wire hilo_div_pkg::word_t dividend_i,
    input  wire hilo_div_pkg::word_t divisor_i,
    input  wire logic                hi_we_i,
    input  wire logic                lo_we_i,
    input  wire hilo_div_pkg::word_t wdata_i,
    output logic                     busy_o,
    output logic                     done_o,
    output hilo_div_pkg::word_t      hi_o,
    output hilo_div_pkg::word_t      lo_o
);

    div_step_if step_bus ();

    hilo_div_pkg::div_work_u div_result;

    div_ctrl_fsm u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start_i  (start_i),
        .cancel_i (cancel_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .bus      (step_bus.ctrl)
    );

    div_step_counter u_counter (
        .clk (clk),
        .rst (rst),
        .bus (step_bus.counter)
    );

    div_datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .signed_i   (signed_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .result_o   (div_result),
        .bus        (step_bus.datapath)
    );

    hilo_regs u_hilo (
        .clk      (clk),
        .rst      (rst),
        .result_i (div_result),
        .hi_we_i  (hi_we_i),
        .lo_we_i  (lo_we_i),
        .wdata_i  (wdata_i),
        .hi_o     (hi_o),
        .lo_o     (lo_o),
        .bus      (step_bus.hilo)
    );

endmodule

`default_nettype wire

// ==== hilo_regs.sv ====
// architectural HI and LO registers
// divider result (rem -> HI, quot -> LO) beats a direct write on the same edge
// both registers clear on reset
`default_nettype none

module hilo_regs (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire hilo_div_pkg::div_work_u result_i,
    input  wire logic                   hi_we_i,
    input  wire logic                   lo_we_i,
    input  wire hilo_div_pkg::word_t    wdata_i,
    output hilo_div_pkg::word_t         hi_o,
    output hilo_div_pkg::word_t         lo_o,
    div_step_if.hilo                    bus
);

    hilo_div_pkg::word_t hi_q;
    hilo_div_pkg::word_t lo_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= '0;
        end else if (bus.finish) begin
            hi_q <= result_i.parts.rem;
        end else if (hi_we_i) begin
            hi_q <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_q <= '0;
        end else if (bus.finish) begin
            lo_q <= result_i.parts.quot;
        end else if (lo_we_i) begin
            lo_q <= wdata_i;
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

`default_nettype wire

// ==== div_datapath.sv ====
// restoring shift-subtract divider, one quotient bit per step
// operands are converted to magnitudes on load when signed_i is set
// signed results: quotient truncates toward zero, remainder follows
// the dividend sign; most negative / -1 wraps to the most negative value
// a zero divisor loads an all-zero working word, so HI = LO = 0
`default_nettype none

module div_datapath (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   signed_i,
    input  wire hilo_div_pkg::word_t    dividend_i,
    input  wire hilo_div_pkg::word_t    divisor_i,
    output hilo_div_pkg::div_work_u     result_o,
    div_step_if.datapath                bus
);

    localparam int W = hilo_div_pkg::DATA_W;

    hilo_div_pkg::div_work_u work_q;
    hilo_div_pkg::div_work_u work_d;
    hilo_div_pkg::word_t     dsor_q;
    hilo_div_pkg::word_t     dvd_mag;
    hilo_div_pkg::word_t     dsor_mag;
    logic                    neg_quot_q;
    logic                    neg_rem_q;
    logic                    dvd_neg;
    logic                    dsor_neg;
    logic [W:0]              trial;
    logic                    fits;

    assign bus.div_zero = (divisor_i == '0);

    assign dvd_neg  = signed_i && dividend_i[W-1];
    assign dsor_neg = signed_i && divisor_i[W-1];

    assign dvd_mag  = dvd_neg ? -dividend_i : dividend_i;
    assign dsor_mag = dsor_neg ? -divisor_i : divisor_i;

    // top W+1 bits of the shifted word with the carry
    assign trial = work_q.raw[2*W-1:W-1] - {1'b0, dsor_q};
    assign fits  = !trial[W];

    always_comb begin
        work_d.parts.quot = {work_q.raw[W-2:0], fits};
        if (fits) begin
            work_d.parts.rem = trial[W-1:0];
        end else begin
            work_d.parts.rem = work_q.raw[2*W-2:W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (bus.load) begin
            dsor_q <= dsor_mag;
            if (bus.div_zero) begin
                work_q.raw <= '0;
            end else begin
                work_q.parts.rem  <= '0;
                work_q.parts.quot <= dvd_mag;
            end
        end else if (bus.step) begin
            work_q <= work_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            neg_quot_q <= 1'b0;
            neg_rem_q  <= 1'b0;
        end else if (bus.load) begin
            neg_quot_q <= !bus.div_zero && (dvd_neg ^ dsor_neg);
            neg_rem_q  <= !bus.div_zero && dvd_neg;
        end
    end

    // sign fix-up
    always_comb begin
        if (neg_quot_q) begin
            result_o.parts.quot = -work_q.parts.quot;
        end else begin
            result_o.parts.quot = work_q.parts.quot;
        end
        if (neg_rem_q) begin
            result_o.parts.rem = -work_q.parts.rem;
        end else begin
            result_o.parts.rem = work_q.parts.rem;
        end
    end

endmodule

`default_nettype wire

// ==== div_step_counter.sv ====
// iteration counter, one count per quotient bit
// last marks the final RUN cycle so the FSM needs no compare
`default_nettype none

module div_step_counter (
    input  wire logic    clk,
    input  wire logic    rst,
    div_step_if.counter  bus
);

    logic [hilo_div_pkg::STEP_CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (bus.load) begin
            count_q <= '0;
        end else if (bus.step) begin
            count_q <= count_q + 1'b1;
        end
    end

    // count still holds the index of the step in progress
    assign bus.last = bus.step &&
        (count_q == hilo_div_pkg::STEP_CNT_W'(hilo_div_pkg::DIV_STEPS - 1));

endmodule

`default_nettype wire

// ==== div_ctrl_fsm.sv ====
// divide sequencer stepping IDLE -> RUN -> DONE -> IDLE
// a zero divisor skips RUN and goes to DONE at the start edge
// cancel while busy returns to IDLE and suppresses the result write
// start is only accepted in IDLE
`default_nettype none

module div_ctrl_fsm (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start_i,
    input  wire logic   cancel_i,
    output logic        busy_o,
    output logic        done_o,
    div_step_if.ctrl    bus
);

    hilo_div_pkg::div_state_e state_q;
    hilo_div_pkg::div_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            hilo_div_pkg::IDLE: begin
                if (start_i) begin
                    if (bus.div_zero) begin
                        state_d = hilo_div_pkg::DONE;
                    end else begin
                        state_d = hilo_div_pkg::RUN;
                    end
                end
            end
            hilo_div_pkg::RUN: begin
                if (cancel_i) begin
                    state_d = hilo_div_pkg::IDLE;
                end else if (bus.last) begin
                    state_d = hilo_div_pkg::DONE;
                end
            end
            hilo_div_pkg::DONE: begin
                state_d = hilo_div_pkg::IDLE;
            end
            default: begin
                state_d = hilo_div_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= hilo_div_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign bus.load = (state_q == hilo_div_pkg::IDLE) && start_i;
    assign bus.step = (state_q == hilo_div_pkg::RUN);

    // a cancel in DONE drops the write as well
    assign bus.finish = (state_q == hilo_div_pkg::DONE) && !cancel_i;

    assign done_o = bus.finish;
    assign busy_o = (state_q != hilo_div_pkg::IDLE);

endmodule

`default_nettype wire

// ==== div_step_if.sv ====
// step controls shared by controller, counter, datapath and HI/LO
// load is a one-cycle strobe; step and finish are levels
`default_nettype none

interface div_step_if;

    logic load;
    logic step;
    logic finish;
    logic last;
    logic div_zero;

    modport ctrl (
        output load,
        output step,
        output finish,
        input  last,
        input  div_zero
    );

    modport counter (
        input  load,
        input  step,
        output last
    );

    modport datapath (
        input  load,
        input  step,
        output div_zero
    );

    modport hilo (
        input  finish
    );

endinterface

`default_nettype wire

// ==== hilo_div_pkg.sv ====
// shared widths and types for the HI/LO divide unit
// widths are fixed at 32 bits; DIV_STEPS must equal DATA_W
// the working word is read raw for the shift and split for HI/LO
`default_nettype none

package hilo_div_pkg;

    localparam int DATA_W     = 32;
    localparam int DIV_STEPS  = 32;
    localparam int STEP_CNT_W = 6;

    typedef logic [DATA_W-1:0] word_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } div_state_e;

    // remainder sits in the upper half, quotient bits enter at the bottom
    typedef struct packed {
        word_t rem;
        word_t quot;
    } div_work_s;

    typedef union packed {
        logic [2*DATA_W-1:0] raw;
        div_work_s           parts;
    } div_work_u;

endpackage

`default_nettype wire
